// ==== files.f ====
+incdir+logic
logic/issue_pkg.sv
logic/unit_issue_if.sv
logic/decode_issue.sv
logic/register_file.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/writeback_arbiter.sv
logic/issue_core.sv
sim/issue_core_sva.sv
sim/issue_core_tb.sv

// ==== Makefile ====
TOP := issue_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir

// ==== sim/issue_core_tb.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

module issue_core_tb;
    import issue_pkg::*;

    typedef logic [8*8-1:0] name_t;

    // Value column carries the cause for exception rows
    typedef struct packed {
        name_t     name;
        instr_t    instr;
        data_t     pc;
        logic      is_exc;
        reg_addr_t rd;
        data_t     value;
    } entry_t;

    localparam logic [6:0] OP_R     = 7'b0110011;
    localparam logic [6:0] OP_I     = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;

    localparam int NUM_TESTS       = 23;
    localparam int NUM_IDS         = 1 << `ISSUE_ID_W;
    localparam int WATCHDOG_CYCLES = 16 + NUM_TESTS * (`MUL_LATENCY + 20);

    //////////////////////////////
    // Stimulus and expected results
    //////////////////////////////
    localparam entry_t TESTS [NUM_TESTS] = '{
        '{"addi_x1 ", {12'd25, 5'd0, 3'b000, 5'd1, OP_I}, 32'h100, 1'b0, 5'd1, 32'h0000_0019},
        '{"addi_neg", {12'hff9, 5'd0, 3'b000, 5'd2, OP_I}, 32'h104, 1'b0, 5'd2, 32'hffff_fff9},
        '{"add     ", {7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP_R}, 32'h108, 1'b0, 5'd3, 32'h12},
        '{"sub     ", {7'h20, 5'd2, 5'd1, 3'b000, 5'd4, OP_R}, 32'h10c, 1'b0, 5'd4, 32'h20},
        '{"and     ", {7'h00, 5'd2, 5'd1, 3'b111, 5'd5, OP_R}, 32'h110, 1'b0, 5'd5, 32'h19},
        '{"or      ", {7'h00, 5'd2, 5'd1, 3'b110, 5'd6, OP_R}, 32'h114, 1'b0, 5'd6, 32'hffff_fff9},
        '{"xor     ", {7'h00, 5'd2, 5'd1, 3'b100, 5'd7, OP_R}, 32'h118, 1'b0, 5'd7, 32'hffff_ffe0},
        '{"lui     ", {20'h12345, 5'd8, OP_LUI}, 32'h11c, 1'b0, 5'd8, 32'h1234_5000},
        '{"auipc   ", {20'h00010, 5'd9, OP_AUIPC}, 32'h2004, 1'b0, 5'd9, 32'h0001_2004},
        // Back-to-back multiplies, low word of the product
        '{"mul_neg ", {7'h01, 5'd2, 5'd1, 3'b000, 5'd10, OP_R}, 32'h2008, 1'b0, 5'd10, 32'hffff_ff51},
        '{"mul_lui ", {7'h01, 5'd1, 5'd8, 3'b000, 5'd11, OP_R}, 32'h200c, 1'b0, 5'd11, 32'hc71b_d000},
        '{"mul_sq  ", {7'h01, 5'd2, 5'd2, 3'b000, 5'd12, OP_R}, 32'h2010, 1'b0, 5'd12, 32'h31},
        '{"add_dep ", {7'h00, 5'd1, 5'd10, 3'b000, 5'd13, OP_R}, 32'h2014, 1'b0, 5'd13, 32'hffff_ff6a},
        // ALU results overtake this multiply
        '{"mul_fwd ", {7'h01, 5'd1, 5'd1, 3'b000, 5'd14, OP_R}, 32'h2018, 1'b0, 5'd14, 32'h271},
        '{"addi_ind", {12'd100, 5'd0, 3'b000, 5'd15, OP_I}, 32'h201c, 1'b0, 5'd15, 32'h64},
        '{"xor_ind ", {7'h00, 5'd1, 5'd1, 3'b100, 5'd16, OP_R}, 32'h2020, 1'b0, 5'd16, 32'h0},
        '{"or_ind  ", {7'h00, 5'd0, 5'd1, 3'b110, 5'd17, OP_R}, 32'h2024, 1'b0, 5'd17, 32'h19},
        '{"illegal ", {12'd0, 5'd1, 3'b010, 5'd5, OP_LOAD}, 32'h2028, 1'b1, 5'd5, 32'd2},
        '{"ecall   ", 32'h0000_0073, 32'h202c, 1'b1, 5'd0, 32'd11},
        '{"addi_aft", {12'd1, 5'd1, 3'b000, 5'd18, OP_I}, 32'h2030, 1'b0, 5'd18, 32'h1a},
        '{"addi_x0 ", {12'd5, 5'd1, 3'b000, 5'd0, OP_I}, 32'h2034, 1'b0, 5'd0, 32'h1e},
        '{"add_x0x0", {7'h00, 5'd0, 5'd0, 3'b000, 5'd19, OP_R}, 32'h2038, 1'b0, 5'd19, 32'h0},
        '{"add_x0x1", {7'h00, 5'd1, 5'd0, 3'b000, 5'd20, OP_R}, 32'h203c, 1'b0, 5'd20, 32'h19}
    };

    logic      clk, rst, decode_valid, flush, exception_ack;
    instr_t    decode_instr;
    data_t     decode_pc;
    id_t       decode_id;
    logic      decode_advance, exception_valid, wb_valid;
    exc_code_t exception_code;
    instr_t    exception_tval;
    id_t       exception_id, wb_id;
    reg_addr_t wb_rd_addr;
    data_t     wb_data;

    // Outstanding instructions by id
    logic [NUM_IDS-1:0] slot_busy;
    int                 slot_idx [NUM_IDS];
    int                 exc_queue [$];

    issue_core dut (
        .clk(clk), .rst(rst), .decode_valid(decode_valid), .decode_instr(decode_instr),
        .decode_pc(decode_pc), .decode_id(decode_id), .flush(flush),
        .decode_advance(decode_advance), .exception_ack(exception_ack),
        .exception_valid(exception_valid), .exception_code(exception_code),
        .exception_tval(exception_tval), .exception_id(exception_id),
        .wb_valid(wb_valid), .wb_rd_addr(wb_rd_addr), .wb_data(wb_data), .wb_id(wb_id)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check_data(input name_t name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_instr(input name_t name, input instr_t expected, input instr_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected tval %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_reg(input name_t name, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected rd %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_code(input name_t name, input exc_code_t expected,
                              input exc_code_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected cause %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_id(input name_t name, input id_t expected, input id_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected id %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // Hold one entry on the decode port until the stage takes it
    task automatic send_entry(input int idx);
        id_t  id;
        logic accepted;
        id = id_t'(idx);
        while (slot_busy[id]) begin
            @(posedge clk);
            #1;
        end
        decode_valid = 1'b1;
        decode_instr = TESTS[idx].instr;
        decode_pc    = TESTS[idx].pc;
        decode_id    = id;
        accepted     = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = decode_advance;
            if (accepted) begin
                slot_busy[id] = 1'b1;
                slot_idx[id]  = idx;
                if (TESTS[idx].is_exc)
                    exc_queue.push_back(idx);
            end
            @(posedge clk);
            #1;
        end
        decode_valid = 1'b0;
    endtask

    //////////////////////////////
    // Writeback and exception monitors
    //////////////////////////////
    initial begin : wb_monitor
        int idx;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (wb_valid) begin
                idx = slot_idx[wb_id];
                if (!slot_busy[wb_id]) begin
                    $display("Writeback with id %0d while no instruction holds that id", wb_id);
                    abort_run();
                end else if (TESTS[idx].is_exc) begin
                    $display("Faulting instruction %s was written back", TESTS[idx].name);
                    abort_run();
                end else begin
                    check_reg(TESTS[idx].name, TESTS[idx].rd, wb_rd_addr);
                    check_data(TESTS[idx].name, TESTS[idx].value, wb_data);
                    slot_busy[wb_id] = 1'b0;
                end
            end
        end
    end

    initial begin : exception_handler
        int idx;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (exception_valid) begin
                if (exc_queue.size() == 0) begin
                    $display("Exception raised while no faulting instruction was sent");
                    abort_run();
                end else begin
                    idx = exc_queue.pop_front();
                    check_code(TESTS[idx].name, exc_code_t'(TESTS[idx].value), exception_code);
                    check_instr(TESTS[idx].name, TESTS[idx].instr, exception_tval);
                    check_id(TESTS[idx].name, id_t'(idx), exception_id);
                    @(posedge clk);
                    #1 exception_ack = 1'b1;
                    @(posedge clk);
                    #1 exception_ack = 1'b0;
                    slot_busy[id_t'(idx)] = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, results still outstanding", WATCHDOG_CYCLES);
        abort_run();
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin : stimulus
        int gap;
        void'($urandom(32'h5464));
        rst           = 1'b1;
        decode_valid  = 1'b0;
        decode_instr  = '0;
        decode_pc     = '0;
        decode_id     = '0;
        flush         = 1'b0;
        exception_ack = 1'b0;
        slot_busy     = '0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            gap = int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_entry(i);
        end
        // Let in-flight results drain, then catch any stray writeback
        while (slot_busy != '0)
            @(posedge clk);
        repeat (2 * `MUL_LATENCY + 4) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== sim/issue_core_sva.sv ====
`timescale 1ns/1ps

module issue_core_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 mul_valid,
    input logic                 mul_ack,
    input logic                 alu_valid,
    input logic                 alu_ack,
    input issue_pkg::id_t       alu_id,
    input issue_pkg::reg_addr_t alu_rd,
    input issue_pkg::data_t     alu_data,
    input issue_pkg::reg_addr_t rs1_addr,
    input logic                 rs1_inuse,
    input issue_pkg::reg_addr_t rd_addr,
    input logic                 rd_inuse,
    input logic                 exception_valid
);

    //////////////////////////////
    // Writeback handshakes
    //////////////////////////////
    one_grant: assert property (@(posedge clk) disable iff (rst) !(mul_ack && alu_ack))
        else $error("Both units granted the write port in one cycle");

    mul_ack_valid: assert property (@(posedge clk) disable iff (rst) mul_ack |-> mul_valid)
        else $error("Multiplier acknowledged without a valid result");

    alu_ack_valid: assert property (@(posedge clk) disable iff (rst) alu_ack |-> alu_valid)
        else $error("ALU acknowledged without a valid result");

    alu_hold: assert property (@(posedge clk) disable iff (rst)
        alu_valid && !alu_ack |=> alu_valid && $stable(alu_data) && $stable(alu_id)
                                  && $stable(alu_rd))
        else $error("ALU result changed or dropped before its grant");

    //////////////////////////////
    // Scoreboard and exceptions
    //////////////////////////////
    x0_rs1_free: assert property (@(posedge clk) disable iff (rst)
        rs1_addr == '0 |-> !rs1_inuse)
        else $error("x0 marked in use on the rs1 lookup");

    x0_rd_free: assert property (@(posedge clk) disable iff (rst) rd_addr == '0 |-> !rd_inuse)
        else $error("x0 marked in use on the rd lookup");

    exc_after_reset: assert property (@(posedge clk) rst |=> !exception_valid)
        else $error("Exception valid right after reset");

endmodule

bind issue_core issue_core_sva sva_i (
    .clk(clk), .rst(rst),
    .mul_valid(mul_wb.valid), .mul_ack(mul_wb.ack),
    .alu_valid(alu_wb.valid), .alu_ack(alu_wb.ack),
    .alu_id(alu_wb.id), .alu_rd(alu_wb.rd_addr), .alu_data(alu_wb.data),
    .rs1_addr(rs1_addr), .rs1_inuse(rs1_inuse),
    .rd_addr(rd_addr), .rd_inuse(rd_inuse),
    .exception_valid(exception_valid)
);

// ==== logic/issue_core.sv ====
`timescale 1ns/1ps

module issue_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 decode_valid,
    input  issue_pkg::instr_t    decode_instr,
    input  issue_pkg::data_t     decode_pc,
    input  issue_pkg::id_t       decode_id,
    input  logic                 flush,
    output logic                 decode_advance,
    input  logic                 exception_ack,
    output logic                 exception_valid,
    output issue_pkg::exc_code_t exception_code,
    output issue_pkg::instr_t    exception_tval,
    output issue_pkg::id_t       exception_id,
    output logic                 wb_valid,
    output issue_pkg::reg_addr_t wb_rd_addr,
    output issue_pkg::data_t     wb_data,
    output issue_pkg::id_t       wb_id
);
    import issue_pkg::*;

    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    data_t     rs1_data, rs2_data;
    logic      rs1_inuse, rs2_inuse, rd_inuse, set_inuse;

    unit_issue_if alu_issue ();
    unit_issue_if mul_issue ();
    wb_if         alu_wb ();
    wb_if         mul_wb ();

    decode_issue decode_issue_i (
        .clk(clk), .rst(rst), .decode_valid(decode_valid), .decode_instr(decode_instr),
        .decode_pc(decode_pc), .decode_id(decode_id), .flush(flush),
        .decode_advance(decode_advance), .exception_ack(exception_ack),
        .exception_valid(exception_valid), .exception_code(exception_code),
        .exception_tval(exception_tval), .exception_id(exception_id),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .rs1_inuse(rs1_inuse),
        .rs2_inuse(rs2_inuse), .rd_inuse(rd_inuse), .set_inuse(set_inuse),
        .alu_issue(alu_issue.decode), .mul_issue(mul_issue.decode)
    );

    // Writeback ports double as the register file write port
    register_file register_file_i (
        .clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .rd_addr(rd_addr),
        .set_inuse(set_inuse), .rs1_inuse(rs1_inuse), .rs2_inuse(rs2_inuse),
        .rd_inuse(rd_inuse), .wr_en(wb_valid), .wr_addr(wb_rd_addr), .wr_data(wb_data)
    );

    alu_unit alu_unit_i (.clk(clk), .rst(rst), .issue(alu_issue.unit), .wb(alu_wb.unit));

    mul_unit mul_unit_i (.clk(clk), .rst(rst), .issue(mul_issue.unit), .wb(mul_wb.unit));

    writeback_arbiter writeback_arbiter_i (
        .mul_wb(mul_wb.arb), .alu_wb(alu_wb.arb), .wr_en(wb_valid),
        .wr_addr(wb_rd_addr), .wr_data(wb_data), .wr_id(wb_id)
    );

endmodule

// ==== logic/writeback_arbiter.sv ====
`timescale 1ns/1ps

module writeback_arbiter (
    wb_if.arb                    mul_wb,
    wb_if.arb                    alu_wb,
    output logic                 wr_en,
    output issue_pkg::reg_addr_t wr_addr,
    output issue_pkg::data_t     wr_data,
    output issue_pkg::id_t       wr_id
);

    logic grant_mul;

    //////////////////////////////
    // Fixed priority grant
    //////////////////////////////
    // Multiplier pipeline cannot hold a result, so it always wins
    assign grant_mul = mul_wb.valid;

    assign mul_wb.ack = grant_mul;
    assign alu_wb.ack = alu_wb.valid & ~grant_mul;

    //////////////////////////////
    // Write port mux
    //////////////////////////////
    assign wr_en = mul_wb.valid | alu_wb.valid;

    always_comb begin
        if (grant_mul) begin
            wr_addr = mul_wb.rd_addr;
            wr_data = mul_wb.data;
            wr_id   = mul_wb.id;
        end else begin
            wr_addr = alu_wb.rd_addr;
            wr_data = alu_wb.data;
            wr_id   = alu_wb.id;
        end
    end

endmodule

// ==== logic/mul_unit.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

module mul_unit #(
    parameter int STAGES = `MUL_LATENCY
) (
    input logic        clk,
    input logic        rst,
    unit_issue_if.unit issue,
    wb_if.unit         wb
);
    import issue_pkg::*;

    logic [STAGES-1:0] valid_q;
    id_t               id_q   [STAGES];
    reg_addr_t         rd_q   [STAGES];
    data_t             prod_q [STAGES];

    //////////////////////////////
    // Pipeline control
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= issue.new_request;
            for (int i = 1; i < STAGES; i++)
                valid_q[i] <= valid_q[i-1];
        end
    end

    //////////////////////////////
    // Product and tags
    //////////////////////////////
    always_ff @(posedge clk) begin
        // Low word only
        prod_q[0] <= issue.rs1_data * issue.rs2_data;
        id_q[0]   <= issue.id;
        rd_q[0]   <= issue.rd_addr;
        for (int i = 1; i < STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
            id_q[i]   <= id_q[i-1];
            rd_q[i]   <= rd_q[i-1];
        end
    end

    // Arbiter always favors this unit so no stall path
    assign issue.ready = 1'b1;

    assign wb.valid   = valid_q[STAGES-1];
    assign wb.id      = id_q[STAGES-1];
    assign wb.rd_addr = rd_q[STAGES-1];
    assign wb.data    = prod_q[STAGES-1];

endmodule

// ==== logic/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input logic        clk,
    input logic        rst,
    unit_issue_if.unit issue,
    wb_if.unit         wb
);
    import issue_pkg::*;

    data_t     alu_out;
    logic      result_valid;
    data_t     result;
    id_t       result_id;
    reg_addr_t result_rd;

    always_comb begin
        case (issue.alu_op)
            ALU_SUB:  alu_out = issue.rs1_data - issue.rs2_data;
            ALU_AND:  alu_out = issue.rs1_data & issue.rs2_data;
            ALU_OR:   alu_out = issue.rs1_data | issue.rs2_data;
            ALU_XOR:  alu_out = issue.rs1_data ^ issue.rs2_data;
            ALU_PASS: alu_out = issue.rs2_data;
            default:  alu_out = issue.rs1_data + issue.rs2_data;
        endcase
    end

    // Result waits here until the arbiter takes it
    always_ff @(posedge clk) begin
        if (rst)
            result_valid <= 1'b0;
        else
            result_valid <= issue.new_request | (result_valid & ~wb.ack);
    end

    always_ff @(posedge clk) begin
        if (issue.new_request) begin
            result    <= alu_out;
            result_id <= issue.id;
            result_rd <= issue.rd_addr;
        end
    end

    assign issue.ready = ~result_valid | wb.ack;

    assign wb.valid   = result_valid;
    assign wb.id      = result_id;
    assign wb.rd_addr = result_rd;
    assign wb.data    = result;

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

module register_file (
    input  logic                 clk,
    input  logic                 rst,
    input  issue_pkg::reg_addr_t rs1_addr,
    input  issue_pkg::reg_addr_t rs2_addr,
    output issue_pkg::data_t     rs1_data,
    output issue_pkg::data_t     rs2_data,
    input  issue_pkg::reg_addr_t rd_addr,
    input  logic                 set_inuse,
    output logic                 rs1_inuse,
    output logic                 rs2_inuse,
    output logic                 rd_inuse,
    input  logic                 wr_en,
    input  issue_pkg::reg_addr_t wr_addr,
    input  issue_pkg::data_t     wr_data
);
    import issue_pkg::*;

    data_t                regs [`NUM_REGS];
    logic [`NUM_REGS-1:0] inuse;

    //////////////////////////////
    // Register storage
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    // x0 reads as zero whatever the array holds
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    //////////////////////////////
    // In-use scoreboard
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            inuse <= '0;
        end else begin
            if (wr_en)
                inuse[wr_addr] <= 1'b0;
            // Set wins over a clear of the same register
            if (set_inuse && rd_addr != '0)
                inuse[rd_addr] <= 1'b1;
        end
    end

    assign rs1_inuse = inuse[rs1_addr];
    assign rs2_inuse = inuse[rs2_addr];
    assign rd_inuse  = inuse[rd_addr];

endmodule

// ==== logic/decode_issue.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

module decode_issue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 decode_valid,
    input  issue_pkg::instr_t    decode_instr,
    input  issue_pkg::data_t     decode_pc,
    input  issue_pkg::id_t       decode_id,
    input  logic                 flush,
    output logic                 decode_advance,
    input  logic                 exception_ack,
    output logic                 exception_valid,
    output issue_pkg::exc_code_t exception_code,
    output issue_pkg::instr_t    exception_tval,
    output issue_pkg::id_t       exception_id,
    output issue_pkg::reg_addr_t rs1_addr,
    output issue_pkg::reg_addr_t rs2_addr,
    output issue_pkg::reg_addr_t rd_addr,
    input  issue_pkg::data_t     rs1_data,
    input  issue_pkg::data_t     rs2_data,
    input  logic                 rs1_inuse,
    input  logic                 rs2_inuse,
    input  logic                 rd_inuse,
    output logic                 set_inuse,
    unit_issue_if.decode         alu_issue,
    unit_issue_if.decode         mul_issue
);
    import issue_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam instr_t     ECALL_WORD = 32'h0000_0073;

    typedef enum logic {EXC_IDLE, EXC_PENDING} exc_state_t;

    exc_state_t exc_state;
    logic       dec_exc, dec_is_mul, dec_uses_rs1, dec_uses_rs2, dec_uses_rd;
    alu_op_t    dec_alu_op;
    data_t      dec_imm;
    logic       issue_valid, issue_exc, issue_is_mul;
    logic       issue_uses_rs1, issue_uses_rs2, issue_uses_rd;
    instr_t     issue_instr;
    id_t        issue_id;
    alu_op_t    issue_alu_op;
    data_t      issue_imm;
    exc_code_t  issue_code;
    logic       operands_ok, unit_ready, issue_fire, issue_free;
    logic       new_exception, exc_drop;
    data_t      operand_b;

    //////////////////////////////
    // Decode of the supported subset
    //////////////////////////////
    always_comb begin
        dec_exc      = 1'b0;
        dec_is_mul   = 1'b0;
        dec_alu_op   = ALU_ADD;
        dec_uses_rs1 = 1'b0;
        dec_uses_rs2 = 1'b0;
        dec_uses_rd  = 1'b0;
        case (decode_instr[6:0])
            OPC_OP: begin
                dec_uses_rs1 = 1'b1;
                dec_uses_rs2 = 1'b1;
                dec_uses_rd  = 1'b1;
                case ({decode_instr[31:25], decode_instr[14:12]})
                    10'b0000000_000: dec_alu_op = ALU_ADD;
                    10'b0100000_000: dec_alu_op = ALU_SUB;
                    10'b0000000_111: dec_alu_op = ALU_AND;
                    10'b0000000_110: dec_alu_op = ALU_OR;
                    10'b0000000_100: dec_alu_op = ALU_XOR;
                    10'b0000001_000: dec_is_mul = 1'b1;
                    default:         dec_exc    = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                dec_uses_rs1 = 1'b1;
                dec_uses_rd  = 1'b1;
                dec_exc      = (decode_instr[14:12] != 3'b000);
            end
            OPC_LUI, OPC_AUIPC: begin
                dec_alu_op  = ALU_PASS;
                dec_uses_rd = 1'b1;
            end
            // ECALL and everything else end up here as exceptions
            default: dec_exc = 1'b1;
        endcase
    end

    // I-type immediate, or the upper immediate on zero or pc
    always_comb begin
        if (decode_instr[6:0] == OPC_OP_IMM)
            dec_imm = {{20{decode_instr[31]}}, decode_instr[31:20]};
        else
            dec_imm = ((decode_instr[6:0] == OPC_LUI) ? '0 : decode_pc)
                      + {decode_instr[31:12], 12'b0};
    end

    //////////////////////////////
    // Issue register
    //////////////////////////////
    assign issue_free     = ~issue_valid | issue_fire | exc_drop;
    assign decode_advance = decode_valid & issue_free & ~flush;

    always_ff @(posedge clk) begin
        if (rst | flush)
            issue_valid <= 1'b0;
        else if (issue_free)
            issue_valid <= decode_valid;
    end

    always_ff @(posedge clk) begin
        if (decode_advance) begin
            issue_instr    <= decode_instr;
            issue_id       <= decode_id;
            issue_exc      <= dec_exc;
            issue_is_mul   <= dec_is_mul;
            issue_alu_op   <= dec_alu_op;
            issue_uses_rs1 <= dec_uses_rs1;
            issue_uses_rs2 <= dec_uses_rs2;
            issue_uses_rd  <= dec_uses_rd;
            issue_imm      <= dec_imm;
            issue_code     <= (decode_instr == ECALL_WORD) ? `EXC_ECALL_M : `EXC_ILLEGAL;
        end
    end

    //////////////////////////////
    // Readiness and unit select
    //////////////////////////////
    assign rs1_addr = issue_instr[19:15];
    assign rs2_addr = issue_instr[24:20];
    assign rd_addr  = issue_instr[11:7];

    assign operands_ok = ~(issue_uses_rs1 & rs1_inuse) & ~(issue_uses_rs2 & rs2_inuse)
                         & ~(issue_uses_rd & rd_inuse);
    assign unit_ready  = issue_is_mul ? mul_issue.ready : alu_issue.ready;
    assign issue_fire  = issue_valid & ~issue_exc & (exc_state == EXC_IDLE)
                         & operands_ok & unit_ready & ~flush;
    assign set_inuse   = issue_fire & issue_uses_rd & (rd_addr != '0);

    // Register operand or latched immediate/constant
    assign operand_b = issue_uses_rs2 ? rs2_data : issue_imm;

    assign alu_issue.new_request = issue_fire & ~issue_is_mul;
    assign alu_issue.id          = issue_id;
    assign alu_issue.rd_addr     = rd_addr;
    assign alu_issue.rs1_data    = rs1_data;
    assign alu_issue.rs2_data    = operand_b;
    assign alu_issue.alu_op      = issue_alu_op;

    assign mul_issue.new_request = issue_fire & issue_is_mul;
    assign mul_issue.id          = issue_id;
    assign mul_issue.rd_addr     = rd_addr;
    assign mul_issue.rs1_data    = rs1_data;
    assign mul_issue.rs2_data    = operand_b;
    assign mul_issue.alu_op      = issue_alu_op;

    //////////////////////////////
    // Exceptions
    //////////////////////////////
    assign new_exception   = issue_valid & issue_exc & (exc_state == EXC_IDLE) & ~flush;
    // Faulting instruction leaves the issue register on ack
    assign exc_drop        = (exc_state == EXC_PENDING) & exception_ack;
    assign exception_valid = (exc_state == EXC_PENDING);

    always_ff @(posedge clk) begin
        if (rst)
            exc_state <= EXC_IDLE;
        else if (new_exception)
            exc_state <= EXC_PENDING;
        else if (exc_drop)
            exc_state <= EXC_IDLE;
    end

    always_ff @(posedge clk) begin
        if (new_exception) begin
            exception_code <= issue_code;
            exception_tval <= issue_instr;
            exception_id   <= issue_id;
        end
    end

endmodule

// ==== logic/unit_issue_if.sv ====
`timescale 1ns/1ps

// Issue stage to one execution unit
interface unit_issue_if;
    import issue_pkg::*;

    logic      ready;
    logic      new_request;
    id_t       id;
    reg_addr_t rd_addr;
    data_t     rs1_data;
    data_t     rs2_data;
    alu_op_t   alu_op;

    modport decode (input ready, output new_request, id, rd_addr, rs1_data, rs2_data, alu_op);
    modport unit (output ready, input new_request, id, rd_addr, rs1_data, rs2_data, alu_op);
endinterface

// Execution unit result to the writeback arbiter
interface wb_if;
    import issue_pkg::*;

    logic      valid;
    logic      ack;
    id_t       id;
    reg_addr_t rd_addr;
    data_t     data;

    modport unit (output valid, id, rd_addr, data, input ack);
    modport arb (input valid, id, rd_addr, data, output ack);
endinterface

// ==== logic/issue_pkg.sv ====
`include "issue_params.svh"

package issue_pkg;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // Operand, result and pc values
    typedef logic [31:0] data_t;

    // Architectural register index
    typedef logic [4:0] reg_addr_t;

    // Tag that follows an instruction to writeback
    typedef logic [`ISSUE_ID_W-1:0] id_t;

    // Exception cause
    typedef logic [3:0] exc_code_t;

    //////////////////////////////
    // ALU functions
    //////////////////////////////

    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_SUB  = 3'd1;
    localparam alu_op_t ALU_AND  = 3'd2;
    localparam alu_op_t ALU_OR   = 3'd3;
    localparam alu_op_t ALU_XOR  = 3'd4;
    // Constant operand straight through, for LUI and AUIPC
    localparam alu_op_t ALU_PASS = 3'd5;

endpackage

// ==== logic/issue_params.svh ====
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// Instruction id width
`define ISSUE_ID_W 3

// Architectural integer registers
`define NUM_REGS 32

// Default multiplier pipeline depth
`define MUL_LATENCY 3

// Exception causes
`define EXC_ILLEGAL 4'd2
`define EXC_ECALL_M 4'd11

`endif
